// File: build.f
logic/video_timing_pkg.sv
logic/frame_buffer_pkg.sv
logic/raster_if.sv
logic/frame_write_if.sv
logic/raster_timing.sv
logic/pixel_packer.sv
logic/frame_store.sv
logic/scan_reader.sv
logic/video_frame_top.sv
+incdir+testbench
testbench/video_frame_tb.sv

// File: logic/frame_buffer_pkg.sv
`default_nettype none

// frame buffer memory layout and slot timing
package frame_buffer_pkg;

   ////////////////////
   // pixel and word packing

   localparam int PIXEL_BITS      = 8;
   localparam int PIXELS_PER_WORD = 4;
   localparam int WORD_BITS       = 36;
   // top bits of a word are parity, written as zero
   localparam int PARITY_BITS     = WORD_BITS - PIXEL_BITS * PIXELS_PER_WORD;

   // one line of 16 pixels is 4 words, 8 lines per frame
   localparam int WORDS_PER_LINE  = 4;
   localparam int FRAME_WORDS     = 32;

   ////////////////////
   // memory slots within a group of four pixel clocks

   localparam int PHASE_BITS = $clog2(PIXELS_PER_WORD);
   typedef logic [PHASE_BITS-1:0] phase_t;

   localparam phase_t READ_PHASE   = phase_t'(0);
   localparam phase_t WRITE_PHASE  = phase_t'(2);
   // cycles from address to data, as on the ZBT part
   localparam int     READ_LATENCY = 2;

   // pixel k of a word sits in bits 8k+7 down to 8k
   typedef logic [PIXEL_BITS-1:0]           pixel_t;
   typedef logic [WORD_BITS-1:0]            mem_word_t;
   typedef logic [$clog2(FRAME_WORDS)-1:0]  mem_addr_t;

endpackage

`default_nettype wire

// File: logic/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

// frame memory with a ZBT-like slotted port
// one shared address, read slot and write slot taken from hcount
module frame_store
   import frame_buffer_pkg::*;
(
   input wire            clk,
   input wire            rst_n,
   raster_if.sink        raster,
   frame_write_if.store  wr,
   input wire mem_addr_t rd_addr,
   output mem_word_t     rd_data
);

   mem_word_t mem [FRAME_WORDS];

   phase_t    phase;
   logic      rd_slot;
   logic      wr_slot;
   mem_addr_t mem_addr;
   // first pipeline stage holds the read address
   mem_addr_t rd_addr_q;
   logic      rd_issue_q;

   ////////////////////
   // slot decode

   assign phase   = raster.hcount[PHASE_BITS-1:0];
   assign rd_slot = (phase == READ_PHASE);
   assign wr_slot = (phase == WRITE_PHASE);

   // single address bus, write address in the write slot
   assign mem_addr = wr_slot ? wr.addr : rd_addr;

   // a pending word goes in at the first write slot it sees
   assign wr.taken = wr_slot && wr.valid;

   ////////////////////
   // read pipeline control

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rd_issue_q <= 1'b0;
      else
         rd_issue_q <= rd_slot;
   end

   ////////////////////
   // memory array

   // data comes out two cycles after the read slot
   // and holds until the next read lands
   always_ff @(posedge clk)
   begin
      if (wr.taken)
         mem[mem_addr] <= wr.data;
      if (rd_slot)
         rd_addr_q <= mem_addr;
      if (rd_issue_q)
         rd_data <= mem[rd_addr_q];
   end

   // a write only lands in the slot where the read data of the group arrives
   write_slot_only: assert property (@(posedge clk) disable iff (!rst_n)
      wr.taken |-> $past(rd_slot, READ_LATENCY));

endmodule

`default_nettype wire

// File: logic/frame_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// one pending memory write from the packer
// addr and data hold still while valid is up and taken is low
interface frame_write_if
   import frame_buffer_pkg::*;
();

   mem_addr_t addr;
   mem_word_t data;
   logic      valid;
   // one-cycle pulse in the write slot that consumed the word
   logic      taken;

   modport writer (
      output addr, data, valid,
      input  taken
   );

   modport store (
      input  addr, data, valid,
      output taken
   );

endinterface

`default_nettype wire

// File: logic/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase pixel intake, four pixels per memory word
// keeps one finished word pending plus one word being filled
module pixel_packer
   import frame_buffer_pkg::*;
(
   input wire           clk,
   input wire           rst_n,
   input wire           pix_req,
   input wire pixel_t   pix_data,
   input wire           pix_start,
   output logic         pix_ack,
   frame_write_if.writer wr
);

   localparam int FILL_BITS = $clog2(PIXELS_PER_WORD);

   // first three pixels of the word in progress, oldest at index 0
   pixel_t [PIXELS_PER_WORD-2:0] part_q;
   logic [FILL_BITS-1:0]         fill_q;
   logic [FILL_BITS-1:0]         fill_eff;
   mem_addr_t                    next_addr_q;
   mem_addr_t                    addr_eff;
   logic                         valid_q;
   logic                         last_pix;
   logic                         stall;
   logic                         accept;

   ////////////////////
   // acceptance

   // a start pixel drops the partial word and begins at address 0
   assign fill_eff = pix_start ? '0 : fill_q;
   assign addr_eff = pix_start ? '0 : next_addr_q;
   assign last_pix = (fill_eff == FILL_BITS'(PIXELS_PER_WORD - 1));
   // the word can only complete once the pending one is gone
   assign stall    = last_pix && valid_q && !wr.taken;
   assign accept   = pix_req && !pix_ack && !stall;
   assign wr.valid = valid_q;

   // ack rises on store and drops only after req has dropped
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pix_ack <= 1'b0;
      else if (accept)
         pix_ack <= 1'b1;
      else if (!pix_req)
         pix_ack <= 1'b0;
   end

   ////////////////////
   // fill count, write address and pending flag

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fill_q      <= '0;
         next_addr_q <= '0;
         valid_q     <= 1'b0;
      end
      else
      begin
         if (wr.taken)
            valid_q <= 1'b0;
         if (accept)
         begin
            if (last_pix)
            begin
               fill_q  <= '0;
               valid_q <= 1'b1;
               // address wraps at the end of the frame
               if (addr_eff == mem_addr_t'(FRAME_WORDS - 1))
                  next_addr_q <= '0;
               else
                  next_addr_q <= addr_eff + 1'b1;
            end
            else
            begin
               fill_q      <= fill_eff + 1'b1;
               next_addr_q <= addr_eff;
            end
         end
      end
   end

   ////////////////////
   // payload

   // new pixels enter at the top and older ones move down
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         part_q <= {pix_data, part_q[PIXELS_PER_WORD-2:1]};
         if (last_pix)
         begin
            wr.addr <= addr_eff;
            wr.data <= {{PARITY_BITS{1'b0}}, pix_data, part_q};
         end
      end
   end

   // four-phase rule seen from the source side
   // req stays up until the pixel has been acknowledged
   req_held: assert property (@(posedge clk) disable iff (!rst_n)
      (pix_req && !pix_ack) |=> pix_req);

   // the store may see a pending word over several slots
   pending_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (wr.valid && !wr.taken) |=> (wr.valid && $stable(wr.addr) && $stable(wr.data)));

endmodule

`default_nettype wire

// File: logic/raster_if.sv
`timescale 1ns/1ps
`default_nettype none

// raster state as produced by the timing generator
// consumers see counts plus registered sync and blank
interface raster_if
   import video_timing_pkg::*;
();

   hcount_t hcount;
   vcount_t vcount;
   logic    hsync;
   logic    vsync;
   // high outside the visible area
   logic    blank;

   modport source (
      output hcount, vcount, hsync, vsync, blank
   );

   // frame_store only looks at the low hcount bits
   modport sink (
      input  hcount, vcount, hsync, vsync, blank
   );

endinterface

`default_nettype wire

// File: logic/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

// horizontal and vertical counters with sync and blank
// all outputs registered so they line up with the counts
module raster_timing
   import video_timing_pkg::*;
(
   input wire       clk,
   input wire       rst_n,
   raster_if.source raster
);

   hcount_t h_next;
   vcount_t v_next;

   ////////////////////
   // next position in the raster

   always_comb
   begin
      h_next = raster.hcount + 1'b1;
      v_next = raster.vcount;
      // end of line wraps the column and steps the line
      if (raster.hcount == hcount_t'(H_TOTAL - 1))
      begin
         h_next = '0;
         if (raster.vcount == vcount_t'(V_TOTAL - 1))
            v_next = '0;
         else
            v_next = raster.vcount + 1'b1;
      end
   end

   ////////////////////
   // state registers

   // sync and blank computed from the next position
   // so they belong to the same cycle as the counts
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         raster.hcount <= '0;
         raster.vcount <= '0;
         raster.hsync  <= 1'b0;
         raster.vsync  <= 1'b0;
         // column 0 of line 0 is visible
         raster.blank  <= 1'b0;
      end
      else
      begin
         raster.hcount <= h_next;
         raster.vcount <= v_next;
         raster.hsync  <= (h_next >= hcount_t'(HSYNC_START)) &&
                          (h_next < hcount_t'(HSYNC_END));
         raster.vsync  <= (v_next == vcount_t'(VSYNC_LINE));
         raster.blank  <= (h_next >= hcount_t'(H_ACTIVE)) ||
                          (v_next >= vcount_t'(V_ACTIVE));
      end
   end

   // slot phases downstream rely on the count staying inside the line
   hcount_range: assert property (@(posedge clk) disable iff (!rst_n)
      raster.hcount < hcount_t'(H_TOTAL));

endmodule

`default_nettype wire

// File: logic/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

// display side of the buffer
// prefetches one word per group and unpacks it byte by byte
module scan_reader
   import video_timing_pkg::*;
   import frame_buffer_pkg::*;
(
   input wire            clk,
   input wire            rst_n,
   raster_if.sink        raster,
   output mem_addr_t     rd_addr,
   input wire mem_word_t rd_data,
   output pixel_t        pix_out,
   output logic          hsync_out,
   output logic          vsync_out,
   output logic          blank_out
);

   localparam int GROUP_BITS = $bits(hcount_t) - PHASE_BITS;
   localparam int GROUPS     = H_TOTAL / PIXELS_PER_WORD;
   // read data settles after the latency, buffer takes it on the last cycle
   localparam phase_t LOAD_PHASE = phase_t'(READ_PHASE + READ_LATENCY + 1);

   logic [GROUP_BITS-1:0] group;
   phase_t                phase;
   mem_addr_t             line_sel;
   mem_addr_t             word_sel;
   mem_word_t             shift_q;

   assign group = raster.hcount[$bits(hcount_t)-1:PHASE_BITS];
   assign phase = raster.hcount[PHASE_BITS-1:0];

   ////////////////////
   // prefetch address

   // word for the next group, line times four plus group
   always_comb
   begin
      if (group == GROUP_BITS'(GROUPS - 1))
      begin
         // last blanking group fetches the start of the next line
         word_sel = '0;
         if (raster.vcount >= vcount_t'(V_ACTIVE - 1))
            line_sel = '0;
         else
            line_sel = mem_addr_t'(raster.vcount + 1'b1);
      end
      else
      begin
         word_sel = mem_addr_t'(group) + 1'b1;
         line_sel = mem_addr_t'(raster.vcount);
      end
   end

   assign rd_addr = mem_addr_t'(line_sel * WORDS_PER_LINE + word_sel);

   ////////////////////
   // unpacking

   // low byte is always the pixel of the current column
   always_ff @(posedge clk)
   begin
      if (phase == LOAD_PHASE)
         shift_q <= rd_data;
      else
         shift_q <= shift_q >> PIXEL_BITS;
   end

   // one register stage for pixel, sync and blank alike
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pix_out   <= '0;
         hsync_out <= 1'b0;
         vsync_out <= 1'b0;
         blank_out <= 1'b1;
      end
      else
      begin
         pix_out   <= shift_q[PIXEL_BITS-1:0];
         hsync_out <= raster.hsync;
         vsync_out <= raster.vsync;
         blank_out <= raster.blank;
      end
   end

endmodule

`default_nettype wire

// File: logic/video_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

// frame buffer top level
// pixel handshake in, raster-ordered pixels with sync out
module video_frame_top
   import frame_buffer_pkg::*;
(
   input wire          clk,
   input wire          rst_n,
   input wire          pix_req,
   input wire pixel_t  pix_data,
   input wire          pix_start,
   output logic        pix_ack,
   output pixel_t      pix_out,
   output logic        hsync_out,
   output logic        vsync_out,
   output logic        blank_out
);

   // read path between reader and memory
   mem_addr_t rd_addr;
   mem_word_t rd_data;

   raster_if      raster ();
   frame_write_if wr ();

   ////////////////////
   // instances

   raster_timing raster_timing_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .raster (raster.source)
   );

   pixel_packer pixel_packer_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .pix_req   (pix_req),
      .pix_data  (pix_data),
      .pix_start (pix_start),
      .pix_ack   (pix_ack),
      .wr        (wr.writer)
   );

   frame_store frame_store_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .raster  (raster.sink),
      .wr      (wr.store),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   scan_reader scan_reader_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .raster    (raster.sink),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .pix_out   (pix_out),
      .hsync_out (hsync_out),
      .vsync_out (vsync_out),
      .blank_out (blank_out)
   );

endmodule

`default_nettype wire

// File: logic/video_timing_pkg.sv
`default_nettype none

// raster geometry for the display side
// sizes shrunk so a whole frame fits in a short simulation
package video_timing_pkg;

   ////////////////////
   // visible area and full raster

   localparam int H_ACTIVE = 16;
   localparam int H_TOTAL  = 24;
   localparam int V_ACTIVE = 8;
   localparam int V_TOTAL  = 10;

   ////////////////////
   // sync placement

   // hsync covers columns HSYNC_START up to HSYNC_END-1
   localparam int HSYNC_START = 18;
   localparam int HSYNC_END   = 21;
   // one vsync line inside vertical blanking
   localparam int VSYNC_LINE  = 9;

   ////////////////////
   // count types

   // wide enough for the full raster, blanking included
   typedef logic [$clog2(H_TOTAL)-1:0] hcount_t;
   typedef logic [$clog2(V_TOTAL)-1:0] vcount_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the frame buffer testbench with Verilator and run it
# the run passes only if the testbench prints its pass message
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f build.f \
      --top-module video_frame_tb -o video_frame_sim \
   && ./obj_dir/video_frame_sim | tee /dev/stderr | grep "Everything OK" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation did not pass"; exit 1; }

// File: testbench/video_checks.svh
`ifndef VIDEO_CHECKS_SVH
`define VIDEO_CHECKS_SVH

// compare tasks used by the stimulus and the raster monitor
// every call counts as one check, a mismatch is printed on the spot

////////////////////
// pixel values

task automatic check_pixel(input string name, input pixel_t expected,
                           input pixel_t actual);
   checks++;
   if (actual !== expected)
   begin
      errors++;
      $display("Mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
   end
endtask

////////////////////
// single-bit levels

// sync, blank and handshake lines
task automatic check_sync(input string name, input logic expected, input logic actual);
   checks++;
   if (actual !== expected)
   begin
      errors++;
      $display("Mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
   end
endtask

////////////////////
// raster counts

// periods and per-frame line counts fit in a column count
task automatic check_count(input string name, input hcount_t expected,
                           input hcount_t actual);
   checks++;
   if (actual !== expected)
   begin
      errors++;
      $display("Mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
   end
endtask

`endif

// File: testbench/video_frame_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the frame buffer top level
// pixels come from the test file, the displayed raster is watched at the outputs
module video_frame_tb
   import video_timing_pkg::*;
   import frame_buffer_pkg::*;
();

   localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

   typedef logic [$clog2(PIXELS_PER_WORD)-1:0] lane_t;

   logic   clk;
   logic   rst_n;
   logic   pix_req;
   pixel_t pix_data;
   logic   pix_start;
   logic   pix_ack;
   pixel_t pix_out;
   logic   hsync_out;
   logic   vsync_out;
   logic   blank_out;

   int errors        = 0;
   int checks        = 0;
   int cycle_count   = 0;
   int timeout_limit = 500;

   // one entry per record of the test file
   byte  rec_kind [$];
   logic rec_start [$];
   int   rec_first [$];
   int   rec_step [$];
   int   rec_count [$];

   // memory contents as the display should see them
   mem_word_t model_mem [FRAME_WORDS];
   mem_word_t model_word;
   lane_t     model_fill;
   mem_addr_t model_addr;

   // raster monitor state
   logic    prev_hsync;
   logic    prev_vsync;
   logic    prev_blank;
   logic    hsync_seen;
   logic    frame_seen;
   hcount_t since_hsync;
   hcount_t run_len;
   hcount_t line_count;
   logic    armed;
   logic    capturing;
   int      pix_index;
   int      frames_checked = 0;

   `include "video_checks.svh"

   video_frame_top video_frame_top_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .pix_req   (pix_req),
      .pix_data  (pix_data),
      .pix_start (pix_start),
      .pix_ack   (pix_ack),
      .pix_out   (pix_out),
      .hsync_out (hsync_out),
      .vsync_out (vsync_out),
      .blank_out (blank_out)
   );

   ////////////////////
   // reference model

   // pixel k of a word goes to bits 8k up, the start pixel restarts at word 0
   task automatic model_push(input logic start, input pixel_t data);
      if (start)
      begin
         model_fill = '0;
         model_addr = '0;
         model_word = '0;
      end
      model_word[PIXEL_BITS * model_fill +: PIXEL_BITS] = data;
      if (model_fill == lane_t'(PIXELS_PER_WORD - 1))
      begin
         model_mem[model_addr] = model_word;
         model_word = '0;
         if (model_addr == mem_addr_t'(FRAME_WORDS - 1))
            model_addr = '0;
         else
            model_addr = model_addr + 1'b1;
      end
      model_fill = model_fill + 1'b1;
   endtask

   // visible pixels in raster order, four per word
   function automatic pixel_t expected_pixel(input int index);
      mem_addr_t waddr;
      lane_t     lane;
      mem_word_t w;
      waddr = mem_addr_t'((index / H_ACTIVE) * WORDS_PER_LINE
                          + (index % H_ACTIVE) / PIXELS_PER_WORD);
      lane  = lane_t'(index % PIXELS_PER_WORD);
      w     = model_mem[waddr];
      return w[PIXEL_BITS * lane +: PIXEL_BITS];
   endfunction

   ////////////////////
   // test file

   task automatic add_record(input byte kind, input int s, input int a, input int b,
                             input int c);
      rec_kind.push_back(kind);
      rec_start.push_back(s != 0);
      rec_first.push_back(a);
      rec_step.push_back(b);
      rec_count.push_back(c);
   endtask

   task automatic load_tests(output int n_pixels, output int n_checks);
      int    fd;
      int    n;
      int    s;
      int    a;
      int    b;
      int    c;
      byte   kind;
      string line;
      n_pixels = 0;
      n_checks = 0;
      fd = $fopen("testbench/video_tests.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("Cannot open testbench/video_tests.txt, no tests were run");
         return;
      end
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() == 0)
            continue;
         kind = line[0];
         case (kind)
            "P":
            begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", s, a, b, c);
               if (n != 4)
               begin
                  errors++;
                  $display("Pixel record with missing fields: %s", line);
               end
               else
               begin
                  add_record(kind, s, a, b, c);
                  n_pixels += c;
               end
            end
            "R":
            begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h", s, c);
               if (n != 2)
               begin
                  errors++;
                  $display("Random record with missing fields: %s", line);
               end
               else
               begin
                  add_record(kind, s, 0, 0, c);
                  n_pixels += c;
               end
            end
            "C":
            begin
               add_record(kind, 0, 0, 0, 0);
               n_checks++;
            end
            // comment or empty line
            "#", "\n", "\r":
               ;
            default:
            begin
               errors++;
               $display("Unknown record in the test file: %s", line);
            end
         endcase
      end
      $fclose(fd);
   endtask

   ////////////////////
   // stimulus

   // full four-phase cycle, outputs looked at on the falling edge
   task automatic send_pixel(input logic start, input pixel_t data);
      @(posedge clk);
      pix_req   <= 1'b1;
      pix_data  <= data;
      pix_start <= start;
      @(negedge clk);
      while (!pix_ack)
         @(negedge clk);
      @(posedge clk);
      pix_req   <= 1'b0;
      pix_start <= 1'b0;
      @(negedge clk);
      while (pix_ack)
         @(negedge clk);
      model_push(start, data);
   endtask

   // arm during vsync, the capture begins at the top of the following frame
   task automatic check_next_frame();
      int target;
      target = frames_checked + 1;
      // room for the last pending word to reach memory
      repeat (8) @(posedge clk);
      @(posedge vsync_out);
      armed = 1'b1;
      while (frames_checked < target)
         @(posedge clk);
   endtask

   ////////////////////
   // clock and timeout

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_limit)
      begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
         $display("Something failed");
         $finish;
      end
   end

   ////////////////////
   // raster monitor

   // sampled on the falling edge, half a cycle after the outputs move
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         prev_hsync  = 1'b0;
         prev_vsync  = 1'b0;
         prev_blank  = 1'b1;
         hsync_seen  = 1'b0;
         frame_seen  = 1'b0;
         since_hsync = '0;
         run_len     = '0;
         line_count  = '0;
         armed       = 1'b0;
         capturing   = 1'b0;
         pix_index   = 0;
      end
      else
      begin
         // hsync period from rising edge to rising edge
         since_hsync = since_hsync + 1'b1;
         if (hsync_out && !prev_hsync)
         begin
            if (hsync_seen)
               check_count("hsync_out period", hcount_t'(H_TOTAL), since_hsync);
            hsync_seen  = 1'b1;
            since_hsync = '0;
         end
         // runs of unblanked pixels make up visible lines
         if (!blank_out)
            run_len = run_len + 1'b1;
         else if (!prev_blank)
         begin
            check_count("visible pixels per line", hcount_t'(H_ACTIVE), run_len);
            line_count = line_count + 1'b1;
            run_len    = '0;
         end
         if (vsync_out && !prev_vsync && frame_seen)
            check_count("visible lines per frame", hcount_t'(V_ACTIVE), line_count);
         // falling vsync is the top of a frame
         if (!vsync_out && prev_vsync)
         begin
            frame_seen = 1'b1;
            line_count = '0;
            if (armed)
            begin
               armed     = 1'b0;
               capturing = 1'b1;
               pix_index = 0;
            end
         end
         if (capturing && !blank_out)
         begin
            check_pixel($sformatf("pix_out[%0d]", pix_index), expected_pixel(pix_index),
                        pix_out);
            pix_index++;
            if (pix_index == FRAME_PIXELS)
            begin
               capturing = 1'b0;
               frames_checked++;
            end
         end
         prev_hsync = hsync_out;
         prev_vsync = vsync_out;
         prev_blank = blank_out;
      end
   end

   ////////////////////
   // main sequence

   initial
   begin : main_sequence
      int n_pixels;
      int n_checks;
      rst_n      = 1'b0;
      pix_req    = 1'b0;
      pix_data   = '0;
      pix_start  = 1'b0;
      model_fill = '0;
      model_addr = '0;
      model_word = '0;
      void'($urandom(57));
      load_tests(n_pixels, n_checks);
      // each check may wait out up to three frames
      timeout_limit = 16 * n_pixels + 3 * FRAME_CYCLES * n_checks + 500;

      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      // reset values hold until the first active edge
      @(negedge clk);
      check_sync("hsync_out", 1'b0, hsync_out);
      check_sync("vsync_out", 1'b0, vsync_out);
      check_sync("blank_out", 1'b1, blank_out);
      check_pixel("pix_out", '0, pix_out);
      check_sync("pix_ack", 1'b0, pix_ack);

      for (int r = 0; r < rec_kind.size(); r++)
      begin
         case (rec_kind[r])
            "P":
               for (int i = 0; i < rec_count[r]; i++)
                  send_pixel(rec_start[r] && (i == 0),
                             pixel_t'(rec_first[r] + i * rec_step[r]));
            "R":
               for (int i = 0; i < rec_count[r]; i++)
                  send_pixel(rec_start[r] && (i == 0), pixel_t'($urandom()));
            default:
               check_next_frame();
         endcase
      end

      repeat (4) @(posedge clk);
      $display("checks %0d, frames compared %0d, errors %0d", checks, frames_checked, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/video_tests.txt
# P start first step count   count pixels first, first+step, ... start flag on the first
# R start count              count random pixels, start flag on the first
# C                          check the next complete displayed frame
#
# a full frame written line by line
P 1 00 01 10
P 0 10 01 10
P 0 20 03 10
P 0 f0 ff 10
P 0 47 05 10
P 0 55 11 10
P 0 80 07 10
P 0 c3 0d 10
C
# a random frame fed back to back
R 1 80
C
# six pixels leave a partial word, the restart rewrites words 0 and 1
P 1 a0 01 06
P 1 e0 02 08
C
